/* sim.f */
source/fp_pkg.sv
source/fp_operand_stage.sv
source/fp_align_add.sv
source/fp_normalize.sv
source/fp_addsub_top.sv
sim/fp_addsub_props.sv
sim/fp_addsub_tb.sv

/* Bender.yml */
package:
  name: fp_addsub

sources:
  # package first, then the stages, then the top level
  - source/fp_pkg.sv
  - source/fp_operand_stage.sv
  - source/fp_align_add.sv
  - source/fp_normalize.sv
  - source/fp_addsub_top.sv

  - target: simulation
    files:
      - sim/fp_addsub_props.sv
      - sim/fp_addsub_tb.sv

/* sim/fp_addsub_tb.sv */
`timescale 1ns/1ns

module fp_addsub_tb;

    import fp_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int n_add        = 300;
    localparam int n_sub        = 300;
    localparam int n_mix        = 200;
    localparam int n_directed   = 16;
    localparam int max_gap      = 3;
    // each operation may be followed by its longest idle gap
    localparam int limit_cycles = reset_cycles + pipe_depth + 50
                                  + (n_add + n_sub + n_mix + n_directed) * (max_gap + 1);

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    fp_op_e   op;
    fp_word_t float_a;
    fp_word_t float_b;
    logic     out_valid;
    fp_word_t float_ans;
    logic     overflow;
    logic     underflow;

    integer seed;
    int     cycle = 0;
    int     word_errors = 0;
    int     flag_errors = 0;
    int     other_errors = 0;

    // expected results in issue order
    fp_word_t exp_word_q[$];
    logic     exp_ovf_q[$];
    logic     exp_udf_q[$];
    int       issue_q[$];

    fp_addsub_top fp_addsub_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .float_a   (float_a),
        .float_b   (float_b),
        .out_valid (out_valid),
        .float_ans (float_ans),
        .overflow  (overflow),
        .underflow (underflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_word(input string name, input fp_word_t expected, input fp_word_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            word_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            flag_errors++;
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            $display("Error at %0t ns: latency expected %0d, got %0d", $time, expected, actual);
            other_errors++;
        end
    endtask

    // reference model of the add/sub rules
    task automatic compute_expected(input fp_op_e o, input fp_word_t a, input fp_word_t b,
                                    output fp_word_t w, output logic ovf, output logic udf);
        logic        a_s;
        logic        b_s;
        logic        swap;
        logic        sgn;
        logic        sub_m;
        logic        g;
        logic        r;
        logic        st;
        logic        is_zero;
        logic [63:0] m_a;
        logic [63:0] m_b;
        logic [63:0] m_big;
        logic [63:0] m_small;
        logic [63:0] sh;
        logic [63:0] sum;
        logic [63:0] norm;
        int          e_a;
        int          e_b;
        int          e_big;
        int          d;
        int          lz;
        int          e_res;
        int          i;
        w   = '0;
        ovf = 1'b0;
        udf = 1'b0;
        a_s = a[exp_width+frac_width];
        b_s = b[exp_width+frac_width];
        e_a = int'(a[frac_width +: exp_width]);
        e_b = int'(b[frac_width +: exp_width]);
        m_a = 64'(a[frac_width-1:0]) | (64'd1 << frac_width);
        m_b = 64'(b[frac_width-1:0]) | (64'd1 << frac_width);
        // strictly larger b swaps, ties keep a
        swap = (e_b > e_a) || ((e_b == e_a) && (m_b > m_a));
        if (o == fp_sub) begin
            sgn = swap ? ~b_s : a_s;
        end else begin
            sgn = swap ? b_s : a_s;
        end
        sub_m   = (o == fp_sub) ^ (a_s ^ b_s);
        m_big   = swap ? m_b : m_a;
        m_small = swap ? m_a : m_b;
        e_big   = swap ? e_b : e_a;
        d       = e_big - (swap ? e_a : e_b);
        g  = 1'b0;
        r  = 1'b0;
        st = 1'b0;
        sh = '0;
        if (d < 26) begin
            sh = m_small >> d;
            // walk the bits that fall off the bottom
            for (i = 0; i < d; i++) begin
                if (i == d - 1) begin
                    g = m_small[i];
                end else if (i == d - 2) begin
                    r = m_small[i];
                end else begin
                    st = st | m_small[i];
                end
            end
            // ties go to even
            if (g && (r || st || sh[0])) sh = sh + 64'd1;
        end
        sum = sub_m ? m_big - sh : m_big + sh;
        is_zero = (o == fp_nop_2) || (o == fp_nop_3) || (sum == 64'd0);
        if (!is_zero) begin
            if (sum[man_width]) begin
                // carry out, truncating right shift
                norm  = sum >> 1;
                e_res = e_big + 1;
            end else begin
                lz = 0;
                while (lz < man_width && !sum[man_width-1-lz]) lz++;
                norm  = sum << lz;
                e_res = e_big - lz;
            end
            if (e_res >= int'(exp_max)) begin
                ovf = 1'b1;
                w   = {sgn, exp_max, {frac_width{1'b0}}};
            end else if (e_res < 1) begin
                udf = 1'b1;
            end else begin
                w = {sgn, e_res[exp_width-1:0], norm[frac_width-1:0]};
            end
        end
    endtask

    task automatic drive_op(input fp_op_e o, input fp_word_t a, input fp_word_t b);
        fp_word_t w;
        logic     ovf;
        logic     udf;
        @(negedge clk);
        in_valid = 1'b1;
        op       = o;
        float_a  = a;
        float_b  = b;
        compute_expected(o, a, b, w, ovf, udf);
        exp_word_q.push_back(w);
        exp_ovf_q.push_back(ovf);
        exp_udf_q.push_back(udf);
        issue_q.push_back(cycle);
    endtask

    // idle cycles now and then, otherwise back to back
    task automatic drive_gap();
        logic [31:0] r;
        int          n;
        n = 0;
        r = $random(seed);
        if (r[1:0] == 2'd0) n = 1 + int'(r[7:2]) % max_gap;
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // normal operands, exponents mostly close together
    task automatic random_pair(output fp_word_t a, output fp_word_t b);
        logic [31:0] r;
        int          e_a;
        int          e_b;
        r   = $random(seed);
        e_a = 1 + int'(r % 254);
        r   = $random(seed);
        if (r[2:0] < 3'd5) begin
            e_b = e_a + int'(r[10:8] % 5) - 2;
            if (e_b < 1) e_b = 1;
            if (e_b > 254) e_b = 254;
        end else begin
            e_b = 1 + int'(r[31:8] % 254);
        end
        a = $random(seed);
        a[frac_width +: exp_width] = e_a[exp_width-1:0];
        b = $random(seed);
        b[frac_width +: exp_width] = e_b[exp_width-1:0];
        // sometimes only the low fraction bits differ
        if (r[2:0] == 3'd0) b[frac_width-1:4] = a[frac_width-1:4];
    endtask

    // scoreboard, outputs settle after the rising edge
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_word_q.size() == 0) begin
                $display("Error at %0t ns: out_valid seen with no operation in flight", $time);
                other_errors++;
            end else begin
                check_word("float_ans", exp_word_q.pop_front(), float_ans);
                check_flag("overflow", exp_ovf_q.pop_front(), overflow);
                check_flag("underflow", exp_udf_q.pop_front(), underflow);
                check_latency(pipe_depth, cycle - issue_q.pop_front());
            end
        end
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        fp_word_t    a;
        fp_word_t    b;
        logic [31:0] r;
        fp_op_e      o;
        int          k;
        seed     = 32'hce6f_7329;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = fp_add;
        float_a  = '0;
        float_b  = '0;
        repeat (reset_cycles) @(negedge clk);
        // output register must come out of reset cleared
        check_flag("out_valid", 1'b0, out_valid);
        check_word("float_ans", '0, float_ans);
        check_flag("overflow", 1'b0, overflow);
        check_flag("underflow", 1'b0, underflow);
        arst_n = 1'b1;

        for (k = 0; k < n_add; k++) begin
            random_pair(a, b);
            drive_op(fp_add, a, b);
            drive_gap();
        end
        for (k = 0; k < n_sub; k++) begin
            random_pair(a, b);
            drive_op(fp_sub, a, b);
            drive_gap();
        end

        // exact cancellation both ways
        for (k = 0; k < 4; k++) begin
            random_pair(a, b);
            drive_op(fp_sub, a, a);
            drive_gap();
            drive_op(fp_add, a, {~a[exp_width+frac_width], a[exp_width+frac_width-1:0]});
        end

        // largest exponent, same sign, carry pushes to 255
        for (k = 0; k < 2; k++) begin
            random_pair(a, b);
            a = {k[0], 8'd254, a[frac_width-1:0]};
            b = {k[0], 8'd254, b[frac_width-1:0]};
            drive_op(fp_add, a, b);
        end

        // one ulp apart at exponent 1
        a = {1'b0, 8'd1, 23'h2a_5c31};
        b = {1'b0, 8'd1, 23'h2a_5c30};
        drive_op(fp_sub, a, b);
        drive_op(fp_add, a, {1'b1, b[exp_width+frac_width-1:0]});

        for (k = 0; k < 4; k++) begin
            random_pair(a, b);
            if (k < 2) begin
                drive_op(fp_nop_2, a, b);
            end else begin
                drive_op(fp_nop_3, a, b);
            end
            drive_gap();
        end

        for (k = 0; k < n_mix; k++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: o = fp_add;
                3'd3, 3'd4, 3'd5: o = fp_sub;
                3'd6: o = fp_nop_2;
                default: o = fp_nop_3;
            endcase
            random_pair(a, b);
            drive_op(o, a, b);
            drive_gap();
        end

        @(negedge clk);
        in_valid = 1'b0;
        // last result is due pipe_depth cycles after its strobe
        repeat (pipe_depth + 2) @(negedge clk);
        if (exp_word_q.size() != 0) begin
            $display("Error at %0t ns: %0d results never came out", $time, exp_word_q.size());
            other_errors++;
        end

        $display("word errors %0d, flag errors %0d, other errors %0d",
                 word_errors, flag_errors, other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim/fp_addsub_props.sv */
`timescale 1ns/1ns

module fp_addsub_props (
    input logic             clk,
    input logic             arst_n,
    input logic             in_valid,
    input logic             out_valid,
    input fp_pkg::fp_word_t float_ans,
    input logic             overflow,
    input logic             underflow
);

    import fp_pkg::*;

    // one result per strobe, fixed latency
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, pipe_depth))
        else $error("out_valid does not follow in_valid by %0d cycles", pipe_depth);

    // no result while held in reset
    assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // flags exclude each other
    assert property (@(posedge clk) disable iff (!arst_n)
        !(overflow && underflow))
        else $error("overflow and underflow high together");

    // underflow always flushes to positive zero
    assert property (@(posedge clk) disable iff (!arst_n)
        underflow |-> (float_ans == '0))
        else $error("underflow with a nonzero result");

endmodule

bind fp_addsub_top fp_addsub_props fp_addsub_props_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .float_ans (float_ans),
    .overflow  (overflow),
    .underflow (underflow)
);

/* source/fp_addsub_top.sv */
`timescale 1ns/1ns

module fp_addsub_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  fp_pkg::fp_op_e   op,
    input  fp_pkg::fp_word_t float_a,
    input  fp_pkg::fp_word_t float_b,
    output logic             out_valid,
    output fp_pkg::fp_word_t float_ans,
    output logic             overflow,
    output logic             underflow
);

    import fp_pkg::*;

    // operand stage outputs
    logic                 s1_valid;
    logic [exp_width-1:0] big_exp;
    logic [exp_width-1:0] small_exp;
    logic [man_width-1:0] big_man;
    logic [man_width-1:0] small_man;
    logic                 s1_res_sign;
    logic                 eff_sub;
    logic                 s1_res_zero;

    // align and add outputs
    logic                 s2_valid;
    logic [man_width:0]   sum_man;
    logic [exp_width-1:0] sum_exp;
    logic                 s2_res_sign;
    logic                 s2_res_zero;

    // unpack, order, sign decision
    fp_operand_stage fp_operand_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .float_a   (float_a),
        .float_b   (float_b),
        .s1_valid  (s1_valid),
        .big_exp   (big_exp),
        .small_exp (small_exp),
        .big_man   (big_man),
        .small_man (small_man),
        .res_sign  (s1_res_sign),
        .eff_sub   (eff_sub),
        .res_zero  (s1_res_zero)
    );

    // align, round the small operand, add or subtract
    fp_align_add fp_align_add_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .s1_valid   (s1_valid),
        .big_exp    (big_exp),
        .small_exp  (small_exp),
        .big_man    (big_man),
        .small_man  (small_man),
        .res_sign   (s1_res_sign),
        .eff_sub    (eff_sub),
        .res_zero   (s1_res_zero),
        .s2_valid   (s2_valid),
        .sum_man    (sum_man),
        .sum_exp    (sum_exp),
        .res_sign_q (s2_res_sign),
        .res_zero_q (s2_res_zero)
    );

    // normalize, special cases, output register
    fp_normalize fp_normalize_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .s2_valid  (s2_valid),
        .sum_man   (sum_man),
        .sum_exp   (sum_exp),
        .res_sign  (s2_res_sign),
        .res_zero  (s2_res_zero),
        .out_valid (out_valid),
        .float_ans (float_ans),
        .overflow  (overflow),
        .underflow (underflow)
    );

endmodule

/* source/fp_normalize.sv */
`timescale 1ns/1ns

module fp_normalize (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                s2_valid,
    input  logic [fp_pkg::man_width:0]          sum_man,
    input  logic [fp_pkg::exp_width-1:0]        sum_exp,
    input  logic                                res_sign,
    input  logic                                res_zero,
    output logic                                out_valid,
    output fp_pkg::fp_word_t                    float_ans,
    output logic                                overflow,
    output logic                                underflow
);

    import fp_pkg::*;

    // or-fold stages, ones fill down from the top set bit
    logic [31:0] fold0;
    logic [31:0] fold1;
    logic [31:0] fold2;
    logic [31:0] fold3;
    logic [31:0] fold4;
    logic [31:0] fold5;

    // population count of the folded word
    logic [31:0] pop1;
    logic [31:0] pop2;
    logic [31:0] pop3;
    logic [31:0] pop4;
    logic [31:0] pop5;

    // leading zeros within 24 bits, 24 for a zero sum
    logic [5:0] lz;

    logic                        carry;
    logic [man_width-1:0]        norm_man;
    // two extra bits so underflow shows as negative
    logic signed [exp_width+1:0] exp_adj;
    logic                        zero_d;
    logic                        ovf_d;
    logic                        udf_d;
    fp_word_t                    ans_d;

    assign carry = sum_man[man_width];

    assign fold0 = {8'd0, sum_man[man_width-1:0]};
    assign fold1 = fold0 | (fold0 >> 1);
    assign fold2 = fold1 | (fold1 >> 2);
    assign fold3 = fold2 | (fold2 >> 4);
    assign fold4 = fold3 | (fold3 >> 8);
    assign fold5 = fold4 | (fold4 >> 16);

    // pairs, nibbles, bytes, then sum of bytes
    assign pop1 = fold5 - ((fold5 >> 1) & 32'h5555_5555);
    assign pop2 = ((pop1 >> 2) & 32'h3333_3333) + (pop1 & 32'h3333_3333);
    assign pop3 = ((pop2 >> 4) + pop2) & 32'h0f0f_0f0f;
    assign pop4 = pop3 + (pop3 >> 8);
    assign pop5 = pop4 + (pop4 >> 16);

    // at most 24 ones, six bits hold the count
    assign lz = 6'd24 - pop5[5:0];

    always_comb begin
        if (carry) begin
            // one step right, the dropped bit is not rounded
            norm_man = sum_man[man_width:1];
            exp_adj  = $signed({2'b00, sum_exp}) + 10'sd1;
        end else begin
            norm_man = sum_man[man_width-1:0] << lz;
            exp_adj  = $signed({2'b00, sum_exp}) - $signed({4'b0000, lz});
        end
    end

    // cancellation, nop or a sum that vanished
    assign zero_d = res_zero || (sum_man == '0);

    // zero wins over both flags
    assign ovf_d = !zero_d && (exp_adj >= $signed({2'b00, exp_max}));
    assign udf_d = !zero_d && !ovf_d && (exp_adj < 10'sd1);

    always_comb begin
        if (zero_d || udf_d) begin
            // always positive zero
            ans_d = '0;
        end else if (ovf_d) begin
            // signed infinity
            ans_d = {res_sign, exp_max, {frac_width{1'b0}}};
        end else begin
            // hidden one dropped
            ans_d = {res_sign, exp_adj[exp_width-1:0], norm_man[frac_width-1:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            float_ans <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            // result held until the next strobe arrives
            if (s2_valid) begin
                float_ans <= ans_d;
                overflow  <= ovf_d;
                underflow <= udf_d;
            end
        end
    end

endmodule

/* source/fp_align_add.sv */
`timescale 1ns/1ns

module fp_align_add (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                s1_valid,
    input  logic [fp_pkg::exp_width-1:0]        big_exp,
    input  logic [fp_pkg::exp_width-1:0]        small_exp,
    input  logic [fp_pkg::man_width-1:0]        big_man,
    input  logic [fp_pkg::man_width-1:0]        small_man,
    input  logic                                res_sign,
    input  logic                                eff_sub,
    input  logic                                res_zero,
    output logic                                s2_valid,
    output logic [fp_pkg::man_width:0]          sum_man,
    output logic [fp_pkg::exp_width-1:0]        sum_exp,
    output logic                                res_sign_q,
    output logic                                res_zero_q
);

    import fp_pkg::*;

    // exponent gap, never negative after ordering
    logic [exp_width-1:0] diff;

    // small mantissa with room below for every bit shifted out
    logic [2*man_width+1:0] ext;
    logic [2*man_width+1:0] ext_sh;

    logic [man_width-1:0] sm_shift;
    logic                 guard_bit;
    logic                 round_bit;
    logic                 sticky_bit;
    logic                 inc;
    logic [man_width-1:0] sm_rnd;
    logic [man_width:0]   sum_d;

    assign diff = big_exp - small_exp;

    // 26 spare bits below the mantissa
    // a gap of 26 or more leaves guard clear and the top part zero
    assign ext    = {small_man, {(man_width+2){1'b0}}};
    assign ext_sh = ext >> diff;

    assign sm_shift   = ext_sh[2*man_width+1 -: man_width];
    assign guard_bit  = ext_sh[man_width+1];
    assign round_bit  = ext_sh[man_width];
    // everything below round
    assign sticky_bit = |ext_sh[man_width-1:0];

    // nearest-even on the aligned operand
    assign inc = guard_bit & (round_bit | sticky_bit | sm_shift[0]);

    // no wrap here, a shifted mantissa is below 2^23 whenever guard can be set
    assign sm_rnd = sm_shift + {{(man_width-1){1'b0}}, inc};

    // big is never smaller, the subtract does not borrow
    always_comb begin
        if (eff_sub) begin
            sum_d = {1'b0, big_man} - {1'b0, sm_rnd};
        end else begin
            sum_d = {1'b0, big_man} + {1'b0, sm_rnd};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // sum and side info follow the strobe
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sum_man    <= sum_d;
            // exponent of big, adjusted later
            sum_exp    <= big_exp;
            res_sign_q <= res_sign;
            res_zero_q <= res_zero;
        end
    end

endmodule

/* source/fp_operand_stage.sv */
`timescale 1ns/1ns

module fp_operand_stage (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  fp_pkg::fp_op_e                      op,
    input  fp_pkg::fp_word_t                    float_a,
    input  fp_pkg::fp_word_t                    float_b,
    output logic                                s1_valid,
    output logic [fp_pkg::exp_width-1:0]        big_exp,
    output logic [fp_pkg::exp_width-1:0]        small_exp,
    output logic [fp_pkg::man_width-1:0]        big_man,
    output logic [fp_pkg::man_width-1:0]        small_man,
    output logic                                res_sign,
    output logic                                eff_sub,
    output logic                                res_zero
);

    import fp_pkg::*;

    // unpacked fields of both operands
    logic                  a_sign;
    logic                  b_sign;
    logic [exp_width-1:0]  a_exp;
    logic [exp_width-1:0]  b_exp;
    logic [frac_width-1:0] a_frac;
    logic [frac_width-1:0] b_frac;

    // decisions ahead of the register
    logic swap;
    logic is_nop;
    logic cancel;
    logic sign_d;
    logic eff_sub_d;

    assign a_sign = float_a[exp_width+frac_width];
    assign b_sign = float_b[exp_width+frac_width];
    assign a_exp  = float_a[frac_width +: exp_width];
    assign b_exp  = float_b[frac_width +: exp_width];
    assign a_frac = float_a[frac_width-1:0];
    assign b_frac = float_b[frac_width-1:0];

    // b becomes big only when strictly larger
    // equal magnitudes keep a in front
    assign swap = (b_exp > a_exp) || ((b_exp == a_exp) && (b_frac > a_frac));

    // mantissas subtract when op and sign difference disagree
    assign eff_sub_d = (op == fp_sub) ^ (a_sign ^ b_sign);

    // equal magnitudes under subtract cancel exactly
    assign cancel = eff_sub_d && (a_exp == b_exp) && (a_frac == b_frac);

    always_comb begin
        sign_d = 1'b0;
        is_nop = 1'b0;
        case (op)
            // add keeps the sign of the larger operand
            fp_add: sign_d = swap ? b_sign : a_sign;
            // sub flips b when b is the larger one
            fp_sub: sign_d = swap ? ~b_sign : a_sign;
            default: is_nop = 1'b1;
        endcase
    end

    // strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // ordered operands, loaded only with a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            big_exp   <= swap ? b_exp : a_exp;
            small_exp <= swap ? a_exp : b_exp;
            // hidden one restored, inputs are normal
            big_man   <= {1'b1, swap ? b_frac : a_frac};
            small_man <= {1'b1, swap ? a_frac : b_frac};
            res_sign  <= sign_d;
            eff_sub   <= eff_sub_d;
            res_zero  <= is_nop || cancel;
        end
    end

endmodule

/* source/fp_pkg.sv */
package fp_pkg;

    // binary32 field sizes
    localparam int exp_width  = 8;
    localparam int frac_width = 23;

    // fraction plus the hidden one
    localparam int man_width  = 24;

    // all-ones biased exponent
    // marks overflow and builds infinity
    localparam logic [exp_width-1:0] exp_max = 8'd255;

    // register stages from in_valid to out_valid
    localparam int pipe_depth = 3;

    // operation select
    // codes 2 and 3 do nothing and give +0
    typedef enum logic [1:0] {
        fp_add   = 2'd0,
        fp_sub   = 2'd1,
        fp_nop_2 = 2'd2,
        fp_nop_3 = 2'd3
    } fp_op_e;

    // sign, exponent, fraction
    typedef logic [exp_width+frac_width:0] fp_word_t;

endpackage
